// ==== btb_config.svh ====
// BTB size macros: sets, index, tag and target widths, ways, update credits
`ifndef BTB_CONFIG_SVH
`define BTB_CONFIG_SVH

// 512 sets, index from PC[10:2]
`define BTB_SETS 512
`define BTB_IDX_W 9

// Partial tag from PC[17:11]
`define BTB_TAG_W 7

// Stored target replaces PC[15:2]
`define BTB_TGT_W 14

`define BTB_WAYS 4

// Update queue depth, also the sender's credit count
`define BTB_UPD_CREDITS 2

`endif

// ==== btb_pkg.sv ====
// BTB shared types: stored way and set, lookup, update and config structs, FSM and address enums
`default_nettype none
`include "btb_config.svh"

package btb_pkg;

  // One stored way, 22 bits
  typedef struct packed {
    logic                  valid;
    logic [`BTB_TAG_W-1:0] tag;
    logic [`BTB_TGT_W-1:0] target;
  } btb_way_t;

  // Whole set, way 0 in the low bits
  typedef struct packed {
    btb_way_t [`BTB_WAYS-1:0] way;
  } btb_set_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } btb_lookup_req_t;

  typedef struct packed {
    logic                        valid;
    logic                        hit;
    logic [$clog2(`BTB_WAYS)-1:0] way;
    logic [31:0]                 target_pc;
  } btb_lookup_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [31:0]           pc;
    logic [`BTB_TGT_W-1:0] target;
  } btb_update_t;

  typedef struct packed {
    logic       valid;
    logic       write;
    logic [1:0] addr;
    logic       data;
  } btb_cfg_req_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] rdata;
  } btb_cfg_rsp_t;

  typedef enum logic [1:0] {IDLE, UPD_READ, UPD_WRITE, FLUSH} btb_state_e;

  // Config register map
  typedef enum logic [1:0] {
    CFG_ENABLE = 2'd0,
    CFG_FLUSH  = 2'd1,
    CFG_HITCNT = 2'd2
  } btb_cfg_addr_e;

endpackage

`default_nettype wire

// ==== spsram_512x44.sv ====
// Behavioral 512x44 single-port SRAM with bit write enables
`timescale 1ns/1ps
`default_nettype none
`include "btb_config.svh"

module spsram_512x44
  import btb_pkg::*;
(
  input  wire logic                  CLK,
  // Chip enable, active low
  input  wire logic                  CEN,
  // High reads, low writes
  input  wire logic                  GWEN,
  // Bit write enables, active low
  input  wire logic [43:0]           WEN,
  input  wire logic [`BTB_IDX_W-1:0] A,
  input  wire logic [43:0]           D,
  output logic      [43:0]           Q
);

  // Each row holds a pair of ways
  btb_way_t [1:0] mem [`BTB_SETS];

  always_ff @(posedge CLK) begin
    if (!CEN) begin
      if (GWEN) begin
        // Read data shows up after the edge
        Q <= mem[A];
      end else begin
        // Keep bits whose enable is high
        mem[A] <= (mem[A] & WEN) | (D & ~WEN);
      end
    end
  end

endmodule

`default_nettype wire

// ==== btb_data_array.sv ====
// BTB data array: two SRAM banks of two ways each, way enable expansion
`timescale 1ns/1ps
`default_nettype none
`include "btb_config.svh"

module btb_data_array
  import btb_pkg::*;
(
  input  wire logic                  forever_cpuclk,
  input  wire logic                  cen_b,
  input  wire logic [`BTB_IDX_W-1:0] index,
  // Per-way write enables, active low
  input  wire logic [`BTB_WAYS-1:0]  way_wen,
  input  wire btb_set_t              wdata,
  output btb_set_t                   rdata
);

  localparam int unsigned WAY_BITS = $bits(btb_way_t);
  localparam int unsigned N_BANKS  = `BTB_WAYS / 2;

  for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
    logic [2*WAY_BITS-1:0] bwen;
    logic                  gwen;

    // Upper way enable covers the upper half of the row
    assign bwen = {{WAY_BITS{way_wen[2*b+1]}}, {WAY_BITS{way_wen[2*b]}}};
    // Bank reads only when neither way writes
    assign gwen = way_wen[2*b+1] & way_wen[2*b];

    spsram_512x44 x_spsram (
      .CLK  (forever_cpuclk          ),
      .CEN  (cen_b                   ),
      .GWEN (gwen                    ),
      .WEN  (bwen                    ),
      .A    (index                   ),
      .D    (wdata.way[2*b+1 -: 2]   ),
      .Q    (rdata.way[2*b+1 -: 2]   )
    );
  end

  // Controller never asks for a write with the chip disabled
  a_wen_idle: assert property (@(posedge forever_cpuclk) cen_b |-> &way_wen);

endmodule

`default_nettype wire

// ==== btb_ctrl.sv ====
// BTB controller: lookup compare, update queue, read-modify-write FSM, flush walk, credits
`timescale 1ns/1ps
`default_nettype none
`include "btb_config.svh"

module btb_ctrl
  import btb_pkg::*;
(
  input  wire logic                  forever_cpuclk,
  input  wire logic                  rst_n,
  input  wire btb_lookup_req_t       lookup_req,
  output btb_lookup_rsp_t            lookup_rsp,
  input  wire btb_update_t           update,
  output logic                       upd_credit,
  input  wire logic                  btb_en,
  input  wire logic                  flush_req,
  output logic                       flush_busy,
  output logic                       hit_pulse,
  output logic                       cen_b,
  output logic [`BTB_IDX_W-1:0]      index,
  output logic [`BTB_WAYS-1:0]       way_wen,
  output btb_set_t                   wdata,
  input  wire btb_set_t              rdata
);

  localparam int unsigned QD      = `BTB_UPD_CREDITS;
  localparam int unsigned QPW     = (QD > 1) ? $clog2(QD) : 1;
  localparam int unsigned WAY_W   = $clog2(`BTB_WAYS);
  localparam int unsigned TAG_LSB = `BTB_IDX_W + 2;
  localparam int unsigned TAG_MSB = TAG_LSB + `BTB_TAG_W - 1;

  btb_state_e            state;
  btb_state_e            state_nxt;
  btb_update_t           upd_q [QD];
  btb_update_t           upd_head;
  logic [QPW-1:0]        wr_ptr;
  logic [QPW-1:0]        rd_ptr;
  logic [QPW:0]          upd_cnt;
  logic                  upd_push;
  logic                  upd_pop;
  logic [`BTB_TAG_W-1:0] upd_tag;
  logic [`BTB_TAG_W-1:0] lkp_tag;
  logic [WAY_W-1:0]      rr_ptr;
  logic [WAY_W-1:0]      sel_way;
  logic [WAY_W-1:0]      hit_way;
  logic                  sel_by_rr;
  logic                  hit_any;
  logic                  flush_pend;
  logic                  flush_go;
  logic [`BTB_IDX_W-1:0] flush_idx;
  logic                  lkp_vld_q;
  logic                  lkp_ok_q;
  logic [31:0]           lkp_pc_q;
  btb_way_t              new_way;

  // Update queue head and tags
  assign upd_push = update.valid;
  assign upd_head = upd_q[rd_ptr];
  assign upd_tag  = upd_head.pc[TAG_MSB:TAG_LSB];
  assign lkp_tag  = lkp_pc_q[TAG_MSB:TAG_LSB];
  assign new_way  = '{valid: 1'b1, tag: upd_tag, target: upd_head.target};
  // A lookup in UPD_WRITE steals the port, so the write retries later
  assign upd_pop  = (state == UPD_WRITE) && !lookup_req.valid;
  assign flush_go = (state == IDLE) && (flush_req || flush_pend);

  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE: begin
        if (flush_go) begin
          state_nxt = FLUSH;
        end else if (!lookup_req.valid && (upd_cnt != '0)) begin
          state_nxt = UPD_READ;
        end
      end
      // Lookup pre-empts the set read
      UPD_READ:  state_nxt = lookup_req.valid ? IDLE : UPD_WRITE;
      UPD_WRITE: state_nxt = IDLE;
      FLUSH:     state_nxt = (&flush_idx) ? IDLE : FLUSH;
      default:   state_nxt = IDLE;
    endcase
  end

  // Victim is a tag match, else first invalid, else round robin
  always_comb begin
    sel_way   = rr_ptr;
    sel_by_rr = 1'b1;
    for (int w = `BTB_WAYS - 1; w >= 0; w--) begin
      if (!rdata.way[w].valid) begin
        sel_way   = WAY_W'(w);
        sel_by_rr = 1'b0;
      end
    end
    for (int w = `BTB_WAYS - 1; w >= 0; w--) begin
      if (rdata.way[w].valid && (rdata.way[w].tag == upd_tag)) begin
        sel_way   = WAY_W'(w);
        sel_by_rr = 1'b0;
      end
    end
  end

  // Lookup compare, lowest matching way wins
  always_comb begin
    hit_any = 1'b0;
    hit_way = '0;
    for (int w = `BTB_WAYS - 1; w >= 0; w--) begin
      if (rdata.way[w].valid && (rdata.way[w].tag == lkp_tag)) begin
        hit_any = 1'b1;
        hit_way = WAY_W'(w);
      end
    end
  end

  // SRAM port priority is flush, then lookup, then update read or write
  always_comb begin
    cen_b   = 1'b1;
    index   = upd_head.pc[TAG_LSB-1:2];
    way_wen = '1;
    for (int w = 0; w < `BTB_WAYS; w++) begin
      wdata.way[w] = new_way;
    end
    if (state == FLUSH) begin
      cen_b   = 1'b0;
      index   = flush_idx;
      way_wen = '0;
      wdata   = '0;
    end else if (lookup_req.valid) begin
      cen_b = 1'b0;
      index = lookup_req.pc[TAG_LSB-1:2];
    end else if (state == UPD_READ) begin
      cen_b = 1'b0;
    end else if (state == UPD_WRITE) begin
      cen_b   = 1'b0;
      way_wen = ~(`BTB_WAYS'(1) << sel_way);
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      state      <= IDLE;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      upd_cnt    <= '0;
      rr_ptr     <= '0;
      flush_pend <= 1'b0;
      flush_idx  <= '0;
      lkp_vld_q  <= 1'b0;
      lkp_ok_q   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (upd_push) begin
        wr_ptr <= (wr_ptr == QPW'(QD - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (upd_pop) begin
        rd_ptr <= (rd_ptr == QPW'(QD - 1)) ? '0 : rd_ptr + 1'b1;
      end
      upd_cnt <= upd_cnt + (QPW+1)'(upd_push) - (QPW+1)'(upd_pop);
      // Pointer only moves on a true replacement
      if (upd_pop && sel_by_rr) begin
        rr_ptr <= rr_ptr + 1'b1;
      end
      // Hold a flush request until IDLE
      flush_pend <= (flush_pend || flush_req) && !flush_go;
      // Wraps back to zero after the last set
      if (state == FLUSH) begin
        flush_idx <= flush_idx + 1'b1;
      end
      lkp_vld_q <= lookup_req.valid;
      // Enable and flush sampled with the request
      lkp_ok_q  <= btb_en && !flush_busy && !flush_req;
    end
  end

  // Queue payload and lookup PC
  always_ff @(posedge forever_cpuclk) begin
    if (upd_push) begin
      upd_q[wr_ptr] <= update;
    end
    if (lookup_req.valid) begin
      lkp_pc_q <= lookup_req.pc;
    end
  end

  assign lookup_rsp.valid     = lkp_vld_q;
  assign lookup_rsp.hit       = lkp_vld_q && lkp_ok_q && hit_any;
  assign lookup_rsp.way       = hit_way;
  assign lookup_rsp.target_pc = {lkp_pc_q[31:`BTB_TGT_W+2], rdata.way[hit_way].target, 2'b00};
  assign hit_pulse            = lookup_rsp.hit;
  assign upd_credit           = upd_pop;
  // Pending counts as busy so a config read never sees 0 too early
  assign flush_busy           = (state == FLUSH) || flush_pend;

  // Sender spends credits, so the queue is never full on a push
  a_no_overflow: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    update.valid |-> (upd_cnt != (QPW+1)'(QD)));

  // Credit only from the write step right after a set read of a queued update
  a_credit_write: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    upd_credit |-> ($past(state) == UPD_READ) && (upd_cnt != '0));

endmodule

`default_nettype wire

// ==== btb_cfg_regs.sv ====
// BTB config registers: enable, flush command and busy, saturating hit counter
`timescale 1ns/1ps
`default_nettype none
`include "btb_config.svh"

module btb_cfg_regs
  import btb_pkg::*;
(
  input  wire logic         forever_cpuclk,
  input  wire logic         rst_n,
  input  wire btb_cfg_req_t cfg_req,
  output btb_cfg_rsp_t      cfg_rsp,
  output logic              btb_en,
  output logic              flush_req,
  input  wire logic         flush_busy,
  input  wire logic         hit_pulse
);

  btb_cfg_addr_e addr;
  logic          wr_en;
  logic [15:0]   hit_cnt;
  logic [15:0]   rd_mux;

  assign addr  = btb_cfg_addr_e'(cfg_req.addr);
  assign wr_en = cfg_req.valid && cfg_req.write;

  // Read mux, unmapped address reads zero
  always_comb begin
    rd_mux = '0;
    case (addr)
      CFG_ENABLE: rd_mux = 16'(btb_en);
      // Flush command in flight also reads busy
      CFG_FLUSH:  rd_mux = 16'(flush_busy || flush_req);
      CFG_HITCNT: rd_mux = hit_cnt;
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      btb_en    <= 1'b0;
      flush_req <= 1'b0;
      hit_cnt   <= '0;
      cfg_rsp   <= '0;
    end else begin
      if (wr_en && (addr == CFG_ENABLE)) begin
        btb_en <= cfg_req.data;
      end
      // One-cycle flush command
      flush_req <= wr_en && (addr == CFG_FLUSH) && cfg_req.data;
      // Saturates at all ones
      if (hit_pulse && !(&hit_cnt)) begin
        hit_cnt <= hit_cnt + 1'b1;
      end
      cfg_rsp.valid <= cfg_req.valid;
      cfg_rsp.rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== btb_top.sv ====
// BTB top level: config registers, controller and data array
`timescale 1ns/1ps
`default_nettype none
`include "btb_config.svh"

module btb_top
  import btb_pkg::*;
(
  input  wire logic            forever_cpuclk,
  input  wire logic            rst_n,
  input  wire btb_lookup_req_t lookup_req,
  output btb_lookup_rsp_t      lookup_rsp,
  input  wire btb_update_t     update,
  output logic                 upd_credit,
  input  wire btb_cfg_req_t    cfg_req,
  output btb_cfg_rsp_t         cfg_rsp
);

  logic                  btb_en;
  logic                  flush_req;
  logic                  flush_busy;
  logic                  hit_pulse;
  // Controller to array
  logic                  cen_b;
  logic [`BTB_IDX_W-1:0] index;
  logic [`BTB_WAYS-1:0]  way_wen;
  btb_set_t              wdata;
  btb_set_t              rdata;

  btb_cfg_regs x_cfg_regs (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .cfg_req        (cfg_req       ),
    .cfg_rsp        (cfg_rsp       ),
    .btb_en         (btb_en        ),
    .flush_req      (flush_req     ),
    .flush_busy     (flush_busy    ),
    .hit_pulse      (hit_pulse     )
  );

  btb_ctrl x_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .lookup_req     (lookup_req    ),
    .lookup_rsp     (lookup_rsp    ),
    .update         (update        ),
    .upd_credit     (upd_credit    ),
    .btb_en         (btb_en        ),
    .flush_req      (flush_req     ),
    .flush_busy     (flush_busy    ),
    .hit_pulse      (hit_pulse     ),
    .cen_b          (cen_b         ),
    .index          (index         ),
    .way_wen        (way_wen       ),
    .wdata          (wdata         ),
    .rdata          (rdata         )
  );

  btb_data_array x_data_array (
    .forever_cpuclk (forever_cpuclk),
    .cen_b          (cen_b         ),
    .index          (index         ),
    .way_wen        (way_wen       ),
    .wdata          (wdata         ),
    .rdata          (rdata         )
  );

endmodule

`default_nettype wire

// ==== btb_checker.sv ====
// BTB checker: reference table, expected lookup function, response, credit and counter checks
`timescale 1ns/1ps
`default_nettype none
`include "btb_config.svh"

module btb_checker
  import btb_pkg::*;
(
  input  wire logic            forever_cpuclk,
  input  wire logic            rst_n,
  input  wire btb_lookup_req_t lookup_req,
  input  wire btb_lookup_rsp_t lookup_rsp,
  input  wire btb_update_t     update,
  input  wire logic            upd_credit,
  input  wire btb_cfg_req_t    cfg_req,
  input  wire btb_cfg_rsp_t    cfg_rsp,
  output int                   errors,
  output int                   checks
);

  // Busy until all sets are walked plus the command cycle
  localparam int FLUSH_MIN = `BTB_SETS + 2;

  btb_way_t        model [`BTB_SETS][`BTB_WAYS];
  btb_update_t     upd_q [$];
  btb_lookup_rsp_t exp_rsp;
  logic            exp_vld;
  logic [31:0]     exp_pc;
  logic [1:0]      rr;
  logic            en;
  logic            flushing;
  int              flush_cycles;
  int              hit_count;
  logic            cfg_pend;
  logic            cfg_rd;
  logic [1:0]      rd_addr;
  logic [15:0]     rd_exp;
  int              rd_age;

  // Index PC[10:2], tag PC[17:11], target replaces PC[15:2]
  function automatic btb_lookup_rsp_t expected_lookup(input logic [31:0] pc);
    btb_lookup_rsp_t r;
    btb_way_t        e;
    r       = '0;
    r.valid = 1'b1;
    for (int w = 0; w < `BTB_WAYS; w++) begin
      e = model[pc[10:2]][2'(w)];
      if (!r.hit && en && !flushing && e.valid && (e.tag == pc[17:11])) begin
        r.hit       = 1'b1;
        r.way       = 2'(w);
        r.target_pc = {pc[31:16], e.target, 2'b00};
      end
    end
    return r;
  endfunction

  // Way choice by matching tag, else first free way, else round robin
  task automatic apply_update(input btb_update_t u);
    logic [8:0] idx;
    int         way;
    idx = u.pc[10:2];
    way = -1;
    for (int w = 0; w < `BTB_WAYS; w++) begin
      if (way < 0 && model[idx][2'(w)].valid && (model[idx][2'(w)].tag == u.pc[17:11])) begin
        way = w;
      end
    end
    for (int w = 0; w < `BTB_WAYS; w++) begin
      if (way < 0 && !model[idx][2'(w)].valid) begin
        way = w;
      end
    end
    if (way < 0) begin
      way = int'(rr);
      rr  = rr + 2'd1;
    end
    model[idx][2'(way)] = '{valid: 1'b1, tag: u.pc[17:11], target: u.target};
  endtask

  task automatic value_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic credit_failure(input string msg);
    errors++;
    $display("Credit protocol broken at time %0t: %s", $time, msg);
  endtask

  always @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      errors    = 0;
      checks    = 0;
      rr        = 2'd0;
      en        = 1'b0;
      flushing  = 1'b0;
      hit_count = 0;
      exp_vld   = 1'b0;
      cfg_pend  = 1'b0;
      upd_q.delete();
    end else begin
      if (flushing) begin
        flush_cycles++;
      end
      // Config response one cycle after any request
      if (cfg_rsp.valid !== cfg_pend) begin
        value_error($sformatf("config response valid %0b, expected %0b",
                              cfg_rsp.valid, cfg_pend));
      end else if (cfg_pend && cfg_rd) begin
        checks++;
        if (rd_addr == CFG_FLUSH) begin
          if (cfg_rsp.rdata == 16'd0) begin
            if (rd_age < FLUSH_MIN) begin
              value_error($sformatf("flush idle after only %0d cycles", rd_age));
            end
            flushing = 1'b0;
          end
        end else if (cfg_rsp.rdata !== rd_exp) begin
          value_error($sformatf("config addr %0d read %0d, expected %0d",
                                rd_addr, cfg_rsp.rdata, rd_exp));
        end
      end
      // Snapshot before this cycle's hit pulse lands
      cfg_pend = cfg_req.valid;
      cfg_rd   = !cfg_req.write;
      rd_addr  = cfg_req.addr;
      rd_age   = flush_cycles;
      rd_exp   = (cfg_req.addr == CFG_HITCNT) ? 16'(hit_count) : 16'(en);
      // Response exactly one cycle after request
      if (lookup_rsp.valid !== exp_vld) begin
        value_error($sformatf("lookup response valid %0b, expected %0b",
                              lookup_rsp.valid, exp_vld));
      end else if (exp_vld) begin
        checks++;
        if (lookup_rsp.hit !== exp_rsp.hit) begin
          value_error($sformatf("pc %h hit %0b, expected %0b", exp_pc, lookup_rsp.hit,
                                exp_rsp.hit));
        end else if (exp_rsp.hit && ((lookup_rsp.way !== exp_rsp.way) ||
                     (lookup_rsp.target_pc !== exp_rsp.target_pc))) begin
          value_error($sformatf("pc %h way %0d target %h, expected way %0d target %h",
                                exp_pc, lookup_rsp.way, lookup_rsp.target_pc,
                                exp_rsp.way, exp_rsp.target_pc));
        end
        if (exp_rsp.hit) begin
          hit_count++;
        end
      end
      exp_vld = lookup_req.valid;
      if (lookup_req.valid) begin
        exp_pc  = lookup_req.pc;
        exp_rsp = expected_lookup(lookup_req.pc);
      end
      // Credit marks the write of the queue head
      if (upd_credit) begin
        if (lookup_req.valid) begin
          credit_failure("update written during a lookup");
        end
        if (upd_q.size() == 0) begin
          credit_failure("credit returned with no update queued");
        end else begin
          apply_update(upd_q.pop_front());
        end
      end
      if (update.valid) begin
        if (upd_q.size() >= `BTB_UPD_CREDITS) begin
          credit_failure("update sent with no credit left");
        end
        upd_q.push_back(update);
      end
      // Register writes take effect after this edge
      if (cfg_req.valid && cfg_req.write) begin
        if (cfg_req.addr == CFG_ENABLE) begin
          en = cfg_req.data;
        end
        if ((cfg_req.addr == CFG_FLUSH) && cfg_req.data) begin
          flushing     = 1'b1;
          flush_cycles = 0;
          for (int s = 0; s < `BTB_SETS; s++) begin
            for (int w = 0; w < `BTB_WAYS; w++) begin
              model[9'(s)][2'(w)] = '0;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== btb_tb.sv ====
// BTB testbench top: clock, reset, LFSR stimulus, credit tracking, timeout and closing report
`timescale 1ns/1ps
`default_nettype none
`include "btb_config.svh"

module btb_tb
  import btb_pkg::*;
();

  // Upper bounds on traffic, sizes the timeout
  localparam int N_UPD       = 69;
  localparam int N_LKP       = 117;
  localparam int CYCLE_LIMIT = 600 + 40 * N_UPD + 3 * N_LKP + 200;

  logic            forever_cpuclk;
  logic            rst_n;
  btb_lookup_req_t lookup_req;
  btb_lookup_rsp_t lookup_rsp;
  btb_update_t     update;
  logic            upd_credit;
  btb_cfg_req_t    cfg_req;
  btb_cfg_rsp_t    cfg_rsp;
  int              errors;
  int              checks;
  int              sent;
  int              returned;
  int              cycles;
  logic [31:0]     lfsr;
  logic [15:0]     rd_val;
  logic [31:0]     r;
  logic [31:0]     pc;
  logic [31:0]     set_pcs [5];

  btb_top uut (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .lookup_req     (lookup_req    ),
    .lookup_rsp     (lookup_rsp    ),
    .update         (update        ),
    .upd_credit     (upd_credit    ),
    .cfg_req        (cfg_req       ),
    .cfg_rsp        (cfg_rsp       )
  );

  btb_checker x_checker (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n         ),
    .lookup_req     (lookup_req    ),
    .lookup_rsp     (lookup_rsp    ),
    .update         (update        ),
    .upd_credit     (upd_credit    ),
    .cfg_req        (cfg_req       ),
    .cfg_rsp        (cfg_rsp       ),
    .errors         (errors        ),
    .checks         (checks        )
  );

  // 100 ns period
  always #50 forever_cpuclk = ~forever_cpuclk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] make_pc(input logic [13:0] hi, input logic [6:0] tag,
                                          input logic [8:0] idx);
    return {hi, tag, idx, 2'b00};
  endfunction

  // Few sets and tags, so hits and evictions both happen
  task automatic pool_pc(output logic [31:0] p);
    logic [31:0] v;
    take_bits(19, v);
    p = make_pc(v[13:0], {4'b0, v[16:14]}, {7'b0, v[18:17]});
  endtask

  task automatic idle_inputs();
    lookup_req = '0;
    update     = '0;
    cfg_req    = '0;
  endtask

  task automatic next_cycle();
    @(negedge forever_cpuclk);
    idle_inputs();
  endtask

  task automatic cfg_access(input logic wr, input logic [1:0] addr, input logic data,
                            output logic [15:0] rdata);
    next_cycle();
    cfg_req = '{valid: 1'b1, write: wr, addr: addr, data: data};
    next_cycle();
    rdata = cfg_rsp.rdata;
  endtask

  task automatic lookup(input logic [31:0] p);
    next_cycle();
    lookup_req = '{valid: 1'b1, pc: p};
  endtask

  // Only sends while a credit is held
  task automatic send_update(input logic [31:0] p, input logic [13:0] tgt);
    next_cycle();
    while (sent - returned >= `BTB_UPD_CREDITS) begin
      next_cycle();
    end
    update = '{valid: 1'b1, pc: p, target: tgt};
    sent++;
  endtask

  task automatic wait_credits();
    while (sent != returned) begin
      next_cycle();
    end
  endtask

  task automatic wait_flush_done();
    rd_val = 16'd1;
    while (rd_val != 16'd0) begin
      cfg_access(1'b0, CFG_FLUSH, 1'b0, rd_val);
    end
  endtask

  always @(posedge forever_cpuclk) begin
    cycles = cycles + 1;
    if (rst_n && upd_credit) begin
      returned = returned + 1;
    end
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    forever_cpuclk = 1'b0;
    rst_n          = 1'b0;
    lfsr           = 32'hea5;
    sent           = 0;
    returned       = 0;
    cycles         = 0;
    idle_inputs();
    repeat (8) @(negedge forever_cpuclk);
    rst_n = 1'b1;
    // Flush from reset, lookups miss during and after
    cfg_access(1'b1, CFG_ENABLE, 1'b1, rd_val);
    cfg_access(1'b1, CFG_FLUSH, 1'b1, rd_val);
    repeat (16) begin
      take_bits(30, r);
      lookup({r[29:0], 2'b00});
    end
    wait_flush_done();
    repeat (4) begin
      take_bits(30, r);
      lookup({r[29:0], 2'b00});
    end
    // Single update then two hits
    take_bits(30, r);
    pc = {r[29:0], 2'b00};
    take_bits(14, r);
    send_update(pc, r[13:0]);
    wait_credits();
    lookup(pc);
    lookup(pc);
    // Five tags into one set, then a repeated tag
    take_bits(9, pc);
    for (int i = 0; i < 5; i++) begin
      take_bits(14, r);
      set_pcs[3'(i)] = make_pc(r[13:0], 7'(8 * i + 3), pc[8:0]);
      take_bits(14, r);
      send_update(set_pcs[3'(i)], r[13:0]);
    end
    take_bits(14, r);
    send_update(set_pcs[3], r[13:0]);
    wait_credits();
    for (int i = 0; i < 5; i++) begin
      lookup(set_pcs[3'(i)]);
    end
    // Updates held back by a lookup burst
    take_bits(14, r);
    send_update(set_pcs[1], r[13:0]);
    take_bits(14, r);
    send_update(set_pcs[2], r[13:0]);
    for (int i = 0; i < 20; i++) begin
      lookup(set_pcs[3'(i % 5)]);
    end
    wait_credits();
    // Disabled lookups miss, re-enable restores hits
    cfg_access(1'b1, CFG_ENABLE, 1'b0, rd_val);
    for (int i = 0; i < 5; i++) begin
      lookup(set_pcs[3'(i)]);
    end
    cfg_access(1'b1, CFG_ENABLE, 1'b1, rd_val);
    for (int i = 0; i < 5; i++) begin
      lookup(set_pcs[3'(i)]);
    end
    // Random mix, then hit counter read back
    for (int i = 0; i < 60; i++) begin
      take_bits(1, r);
      pool_pc(pc);
      if (r[0]) begin
        take_bits(14, r);
        send_update(pc, r[13:0]);
      end else begin
        lookup(pc);
      end
    end
    wait_credits();
    repeat (2) next_cycle();
    cfg_access(1'b0, CFG_HITCNT, 1'b0, rd_val);
    repeat (2) next_cycle();
    $display("Run done: %0d checks, %0d errors, %0d updates, %0d credits returned",
             checks, errors, sent, returned);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
btb_pkg.sv
spsram_512x44.sv
btb_data_array.sv
btb_ctrl.sv
btb_cfg_regs.sv
btb_top.sv
btb_checker.sv
btb_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the BTB testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
  --top-module btb_tb -o btb_sim > build.log 2>&1 &&
  ./obj_dir/btb_sim > sim.log 2>&1 ||
  { cat build.log sim.log 2> /dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; } ||
  { echo "Simulation finished without failure"; exit 0; }
